// File: include/cpu_settings.svh
//********************
// word, register and instruction field widths
// for the four-stage 16-bit CPU
//********************

`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// data and instruction words share one width
`define CPU_WORD_BITS 16

// register file
`define CPU_NUM_REGS 8
`define CPU_REG_BITS 3

// instruction fields
`define CPU_OPCODE_BITS 3
`define CPU_IMM_BITS 9

`endif

// File: rtl/cpuPkg.sv
//********************
// opcode and ALU enums, instruction word union,
// stage structs passed between pipeline stages
//********************

`include "cpu_settings.svh"

package cpuPkg;

    typedef enum logic [`CPU_OPCODE_BITS-1:0] {
        mv    = 3'd0,
        mvtB  = 3'd1, // mvt with immFlag set, b otherwise
        add   = 3'd2,
        sub   = 3'd3,
        ld    = 3'd4,
        st    = 3'd5,
        andOp = 3'd6,
        nop   = 3'd7
    } opcodeE;

    typedef enum logic [2:0] {
        aluNone,
        aluMove,
        aluAdd,
        aluSub,
        aluAnd,
        aluHigh // low immediate byte into the upper byte
    } aluOpE;

    typedef union packed {
        struct packed {
            opcodeE                   opcode;
            logic                     immFlag;
            logic [`CPU_REG_BITS-1:0] rX;
            logic [5:0]               pad; // unused in register form
            logic [`CPU_REG_BITS-1:0] rY;
        } regForm;
        struct packed {
            opcodeE                   opcode;
            logic                     immFlag;
            logic [`CPU_REG_BITS-1:0] rX;
            logic [`CPU_IMM_BITS-1:0] imm9; // signed
        } immForm;
    } instrWordU;

    typedef struct packed {
        logic                      valid;
        aluOpE                     aluOp;
        logic                      isBranch;
        logic                      isLoad;
        logic                      isStore;
        logic                      writeback;
        logic [`CPU_REG_BITS-1:0]  rX;
        logic [`CPU_WORD_BITS-1:0] operandA; // value of rX
        logic [`CPU_WORD_BITS-1:0] operandB; // rY or sign-extended immediate
        logic [`CPU_WORD_BITS-1:0] pcNext;
    } decodedOpS;

    typedef struct packed {
        logic                      valid;
        logic                      isLoad;
        logic                      isStore;
        logic                      writeback;
        logic [`CPU_REG_BITS-1:0]  rX;
        logic [`CPU_WORD_BITS-1:0] result; // also the data address for ld/st
        logic [`CPU_WORD_BITS-1:0] storeData;
    } execResultS;

    typedef struct packed {
        logic                      valid;
        logic [`CPU_REG_BITS-1:0]  rX;
        logic [`CPU_WORD_BITS-1:0] value;
    } writebackS;

endpackage

// File: rtl/regFile.sv
//********************
// register file: eight words, two read ports,
// one write port with write-through
//********************

`timescale 1ns/100ps

`include "cpu_settings.svh"

module regFile import cpuPkg::*; (
    input  logic                      Clock,
    input  logic                      Reset,
    input  logic [`CPU_REG_BITS-1:0]  readIndexA,
    input  logic [`CPU_REG_BITS-1:0]  readIndexB,
    output logic [`CPU_WORD_BITS-1:0] readDataA,
    output logic [`CPU_WORD_BITS-1:0] readDataB,
    input  writebackS                 wb
);

    logic [`CPU_WORD_BITS-1:0] regs [`CPU_NUM_REGS];

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            for (int i = 0; i < `CPU_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid) begin
            regs[wb.rX] <= wb.value;
        end
    end

    // a read of the register being written sees the new value
    assign readDataA = (wb.valid && wb.rX == readIndexA) ? wb.value : regs[readIndexA];
    assign readDataB = (wb.valid && wb.rX == readIndexB) ? wb.value : regs[readIndexB];

endmodule

// File: rtl/instrDecode.sv
//********************
// decode stage: splits the fetched word, reads
// operands and registers the decoded operation
//********************

`timescale 1ns/100ps

`include "cpu_settings.svh"

module instrDecode import cpuPkg::*; (
    input  logic                      Clock,
    input  logic                      Reset,
    input  logic                      stall,
    input  logic                      flush,
    input  instrWordU                 instrWord,
    input  logic [`CPU_WORD_BITS-1:0] pc,
    output logic [`CPU_REG_BITS-1:0]  readIndexA,
    output logic [`CPU_REG_BITS-1:0]  readIndexB,
    input  logic [`CPU_WORD_BITS-1:0] readDataA,
    input  logic [`CPU_WORD_BITS-1:0] readDataB,
    output decodedOpS                 decoded
);

    decodedOpS                 next;
    logic [`CPU_WORD_BITS-1:0] immExt;
    logic                      isZeroWord;

    assign readIndexA = instrWord.immForm.rX;
    assign readIndexB = instrWord.regForm.rY;

    assign immExt = {{(`CPU_WORD_BITS-`CPU_IMM_BITS){instrWord.immForm.imm9[`CPU_IMM_BITS-1]}},
                     instrWord.immForm.imm9};
    assign isZeroWord = (instrWord == '0); // the all-zero word is a no-op

    always_comb begin
        next          = '0;
        next.valid    = !isZeroWord;
        next.rX       = instrWord.immForm.rX;
        next.operandA = readDataA;
        next.operandB = instrWord.immForm.immFlag ? immExt : readDataB;
        next.pcNext   = pc + 1'b1;
        case (instrWord.immForm.opcode)
            mv: begin
                next.aluOp     = aluMove;
                next.writeback = 1'b1;
            end
            mvtB: begin
                if (instrWord.immForm.immFlag) begin
                    next.aluOp     = aluHigh; // mvt
                    next.writeback = 1'b1;
                end else begin
                    next.isBranch = 1'b1; // b with signed offset
                    next.operandB = immExt;
                end
            end
            add: begin
                next.aluOp     = aluAdd;
                next.writeback = 1'b1;
            end
            sub: begin
                next.aluOp     = aluSub;
                next.writeback = 1'b1;
            end
            ld: begin
                next.aluOp     = aluMove; // operandB passes through as the address
                next.isLoad    = 1'b1;
                next.writeback = 1'b1;
            end
            st: begin
                next.aluOp   = aluMove;
                next.isStore = 1'b1;
            end
            andOp: begin
                next.aluOp     = aluAnd;
                next.writeback = 1'b1;
            end
            default: next.valid = 1'b0; // opcode 111
        endcase
    end

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            decoded <= '0;
        end else if (!stall) begin
            if (flush || !next.valid) begin
                decoded <= '0; // bubble
            end else begin
                decoded <= next;
            end
        end
    end

    // a taken branch in the decode register is followed by a bubble
    assert property (@(posedge Clock) disable iff (Reset)
        decoded.valid && decoded.isBranch && !stall |=> !decoded.valid)
        else $error("instruction after a taken branch was not flushed");

endmodule

// File: rtl/aluExecute.sv
//********************
// execute stage: ALU, branch target and decision,
// execute pipeline register
//********************

`timescale 1ns/100ps

`include "cpu_settings.svh"

module aluExecute import cpuPkg::*; (
    input  logic                      Clock,
    input  logic                      Reset,
    input  logic                      stall,
    input  decodedOpS                 decoded,
    output logic                      branchTaken,
    output logic [`CPU_WORD_BITS-1:0] branchTarget,
    output execResultS                result
);

    localparam int HalfBits = `CPU_WORD_BITS / 2;

    logic [`CPU_WORD_BITS-1:0] aluOut;

    always_comb begin
        case (decoded.aluOp)
            aluMove: aluOut = decoded.operandB;
            aluAdd:  aluOut = decoded.operandA + decoded.operandB;
            aluSub:  aluOut = decoded.operandA - decoded.operandB;
            aluAnd:  aluOut = decoded.operandA & decoded.operandB;
            aluHigh: aluOut = {decoded.operandB[HalfBits-1:0], {HalfBits{1'b0}}};
            default: aluOut = '0;
        endcase
    end

    assign branchTarget = decoded.pcNext + decoded.operandB;
    assign branchTaken  = decoded.valid && decoded.isBranch && !stall;

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            result <= '0;
        end else if (!stall) begin
            result.valid     <= decoded.valid;
            result.isLoad    <= decoded.isLoad;
            result.isStore   <= decoded.isStore;
            result.writeback <= decoded.writeback; // clear for branches
            result.rX        <= decoded.rX;
            result.result    <= aluOut;
            result.storeData <= decoded.operandA;
        end
    end

    // a branch held by a stall stays pending and redirects the PC once the stall ends
    assert property (@(posedge Clock) disable iff (Reset)
        stall && decoded.valid && decoded.isBranch |=> decoded.valid && decoded.isBranch)
        else $error("branch dropped during stall");

endmodule

// File: rtl/memResult.sv
//********************
// memory stage: data port request with wait
// handshake, writeback register
//********************

`timescale 1ns/100ps

`include "cpu_settings.svh"

module memResult import cpuPkg::*; (
    input  logic                      Clock,
    input  logic                      Reset,
    input  execResultS                exec,
    output logic [`CPU_WORD_BITS-1:0] DataAddr,
    output logic [`CPU_WORD_BITS-1:0] DataOut,
    output logic                      ReadData,
    output logic                      WriteData,
    input  logic [`CPU_WORD_BITS-1:0] DataIn,
    input  logic                      DataWaitreq,
    output logic                      memBusy,
    output writebackS                 wb
);

    logic                      request;
    logic [`CPU_WORD_BITS-1:0] wbValue;

    // request comes straight from the execute register, which holds while busy
    assign ReadData  = exec.valid && exec.isLoad;
    assign WriteData = exec.valid && exec.isStore;
    assign DataAddr  = exec.result;
    assign DataOut   = exec.storeData;

    assign request = ReadData || WriteData;
    assign memBusy = request && DataWaitreq;

    assign wbValue = exec.isLoad ? DataIn : exec.result; // DataIn valid on completion

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            wb <= '0;
        end else begin
            wb.valid <= exec.valid && exec.writeback && !memBusy;
            wb.rX    <= exec.rX;
            wb.value <= wbValue;
        end
    end

    assert property (@(posedge Clock) disable iff (Reset) !(ReadData && WriteData))
        else $error("read and write requested together");

    // request must hold steady until the wait is released
    assert property (@(posedge Clock) disable iff (Reset)
        memBusy |=> $stable({ReadData, WriteData, DataAddr, DataOut}))
        else $error("data request changed during wait");

endmodule

// File: rtl/cpuCore.sv
//********************
// top level of the four-stage CPU: PC and fetch,
// stall and flush wiring, stage instances
//********************

`timescale 1ns/100ps

`include "cpu_settings.svh"

module cpuCore import cpuPkg::*; (
    input  logic                      Clock,
    input  logic                      Reset,
    output logic [`CPU_WORD_BITS-1:0] InstrAddr,
    input  logic [`CPU_WORD_BITS-1:0] InstrIn,
    output logic [`CPU_WORD_BITS-1:0] DataAddr,
    output logic [`CPU_WORD_BITS-1:0] DataOut,
    input  logic [`CPU_WORD_BITS-1:0] DataIn,
    output logic                      ReadData,
    output logic                      WriteData,
    input  logic                      DataWaitreq
);

    logic [`CPU_WORD_BITS-1:0] pc;
    logic [`CPU_WORD_BITS-1:0] branchTarget;
    logic [`CPU_WORD_BITS-1:0] readDataA;
    logic [`CPU_WORD_BITS-1:0] readDataB;
    logic [`CPU_REG_BITS-1:0]  readIndexA;
    logic [`CPU_REG_BITS-1:0]  readIndexB;
    logic                      branchTaken;
    logic                      memBusy;
    instrWordU                 instrWord;
    decodedOpS                 decoded;
    execResultS                execResult;
    writebackS                 wb;

    assign InstrAddr = pc;
    assign instrWord = instrWordU'(InstrIn); // async ROM, word belongs to this pc

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            pc <= '0;
        end else if (branchTaken) begin
            pc <= branchTarget;
        end else if (!memBusy) begin
            pc <= pc + 1'b1;
        end
    end

    regFile u_regFile (
        .Clock, .Reset, .readIndexA, .readIndexB, .readDataA, .readDataB, .wb
    );

    instrDecode u_instrDecode (
        .Clock, .Reset, .stall(memBusy), .flush(branchTaken), .instrWord, .pc,
        .readIndexA, .readIndexB, .readDataA, .readDataB, .decoded
    );

    aluExecute u_aluExecute (
        .Clock, .Reset, .stall(memBusy), .decoded, .branchTaken, .branchTarget,
        .result(execResult)
    );

    memResult u_memResult (
        .Clock, .Reset, .exec(execResult), .DataAddr, .DataOut, .ReadData, .WriteData,
        .DataIn, .DataWaitreq, .memBusy, .wb
    );

endmodule

// File: verification/cpuCore_tb.sv
//********************
// testbench for the four-stage CPU:
// clock and reset, instruction ROM, data memory
// with random wait states, store checker, watchdog
//********************

`timescale 1ns/100ps

`include "cpu_settings.svh"

module cpuCore_tb;

    localparam int ClockPeriod = 4;
    localparam int MemWords    = 1 << `CPU_WORD_BITS;

    logic                      Clock;
    logic                      Reset;
    logic [`CPU_WORD_BITS-1:0] InstrAddr;
    logic [`CPU_WORD_BITS-1:0] InstrIn;
    logic [`CPU_WORD_BITS-1:0] DataAddr;
    logic [`CPU_WORD_BITS-1:0] DataOut;
    logic [`CPU_WORD_BITS-1:0] DataIn;
    logic                      ReadData;
    logic                      WriteData;
    logic                      DataWaitreq;

    logic [`CPU_WORD_BITS-1:0] rom [MemWords];
    logic [`CPU_WORD_BITS-1:0] dataMem [MemWords];
    logic [`CPU_WORD_BITS-1:0] expAddr [$];
    logic [`CPU_WORD_BITS-1:0] expValue [$];
    logic [`CPU_WORD_BITS-1:0] endAddr;   // address of the final self-branch
    logic [31:0]               lfsr;
    int                        numWords;
    int                        checkCount;
    int                        errorCount;
    int                        storeCount;
    int                        storeErrors;
    int                        holdChecks;
    int                        holdErrors;
    bit                        loadDone;
    bit                        vectorsOk;

    cpuCore u_cpuCore (
        .Clock, .Reset, .InstrAddr, .InstrIn, .DataAddr, .DataOut, .DataIn,
        .ReadData, .WriteData, .DataWaitreq
    );

    assign InstrIn = rom[InstrAddr]; // asynchronous ROM

    initial begin
        Clock = 1'b0;
        forever #(ClockPeriod / 2) Clock = ~Clock;
    end

    function automatic logic [31:0] nextLfsr(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]}; // taps 32,22,2,1
    endfunction

    task automatic checkValue(input string what, input logic [63:0] got,
                              input logic [63:0] expected, output bit ok);
        checkCount++;
        ok = (got === expected);
        if (!ok) begin
            errorCount++;
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, expected);
        end
    endtask

    task automatic loadVectors();
        int    fd;
        int    fields;
        int    n;
        string line;
        byte   tag;
        logic [`CPU_WORD_BITS-1:0] addr;
        logic [`CPU_WORD_BITS-1:0] value;
        for (int i = 0; i < MemWords; i++) begin
            rom[i]     = '0;
            dataMem[i] = '0;
        end
        fd = $fopen("verification/cpu_vectors.txt", "r");
        vectorsOk = (fd != 0);
        if (!vectorsOk) begin
            errorCount++;
            $display("could not open verification/cpu_vectors.txt");
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n == 0 || line.len() < 3 || line[0] == "#") continue; // blank or comment
            fields = $sscanf(line, "%c %h %h", tag, addr, value);
            if (fields != 3) tag = "?";
            case (tag)
                "I": begin
                    rom[addr] = value;
                    numWords++;
                    endAddr = addr;
                end
                "M": dataMem[addr] = value;
                "S": begin
                    expAddr.push_back(addr);
                    expValue.push_back(value);
                end
                default: begin
                    errorCount++;
                    $display("vectors file holds a line that cannot be read: %s", line);
                end
            endcase
        end
        $fclose(fd);
    endtask

    // a completed store updates memory and is matched against the next expected one
    task automatic recordStore(input logic [`CPU_WORD_BITS-1:0] addr,
                               input logic [`CPU_WORD_BITS-1:0] value);
        bit okAddr;
        bit okValue;
        dataMem[addr] = value;
        if (storeCount < expAddr.size()) begin
            checkValue($sformatf("store %0d address", storeCount), 64'(addr),
                       64'(expAddr[storeCount]), okAddr);
            checkValue($sformatf("store %0d value", storeCount), 64'(value),
                       64'(expValue[storeCount]), okValue);
            if (!okAddr || !okValue) storeErrors++;
        end else begin
            errorCount++;
            $display("unexpected store number %0d to address %h at %0t ns",
                     storeCount, addr, $time);
        end
        storeCount++;
    endtask

    initial begin : dataMemoryModel
        logic [33:0] heldRequest;
        logic [1:0]  waitLeft;
        bit          inRequest;
        bit          ok;
        DataIn      = '0;
        DataWaitreq = 1'b0;
        lfsr        = 32'h328024b8;
        inRequest   = 1'b0;
        waitLeft    = '0;
        heldRequest = '0;
        forever begin
            @(posedge Clock);
            #1;
            if (inRequest) begin // waited last cycle, request must be unchanged
                holdChecks++;
                checkValue("request during wait", 64'({ReadData, WriteData, DataAddr, DataOut}),
                           64'(heldRequest), ok);
                if (!ok) holdErrors++;
            end else if (ReadData || WriteData) begin
                inRequest   = 1'b1;
                heldRequest = {ReadData, WriteData, DataAddr, DataOut};
                for (int i = 0; i < 2; i++) begin
                    lfsr     = nextLfsr(lfsr);
                    waitLeft = {waitLeft[0], lfsr[0]};
                end
            end
            DataIn      = dataMem[DataAddr];
            DataWaitreq = inRequest && (waitLeft != 0);
            if (inRequest && waitLeft != 0) begin
                waitLeft--;
            end else if (inRequest) begin
                inRequest = 1'b0; // completes in this cycle
                if (WriteData) recordStore(DataAddr, DataOut);
            end
        end
    end

    task automatic runProgram();
        logic [`CPU_WORD_BITS-1:0] lastAddr;
        int                        arrivals;
        int                        cycles;
        bit                        ok;
        arrivals = 0;
        cycles   = 0;
        lastAddr = InstrAddr;
        while (arrivals < 2) begin // second arrival means the self-branch was taken
            @(negedge Clock);
            cycles++;
            if (InstrAddr == endAddr && lastAddr != endAddr) arrivals++;
            lastAddr = InstrAddr;
        end
        checkValue("stores before final branch", 64'(storeCount), 64'(expAddr.size()), ok);
        $display("program run: final branch reached after %0d cycles", cycles);
        repeat (8) @(negedge Clock); // a late stray store would show up here
        $display("store values: %0d compared, %0d wrong", storeCount, storeErrors);
        $display("request hold: %0d wait cycles, %0d changed", holdChecks, holdErrors);
    endtask

    initial begin : mainSequence
        int startErrors;
        bit ok;
        Reset = 1'b1;
        loadVectors();
        loadDone = 1'b1;
        repeat (2) @(posedge Clock);
        #1;
        Reset = 1'b0;
        #2;
        startErrors = errorCount;
        checkValue("InstrAddr after reset", 64'(InstrAddr), 64'(0), ok);
        checkValue("ReadData after reset", 64'(ReadData), 64'(0), ok);
        checkValue("WriteData after reset", 64'(WriteData), 64'(0), ok);
        $display("reset state: %s", (errorCount == startErrors) ? "pass" : "fail");
        if (vectorsOk) runProgram();
        checkValue("store count", 64'(storeCount), 64'(expAddr.size()), ok);
        $display("store count: %0d seen, %0d expected", storeCount, expAddr.size());
        $display("%0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        int limitCycles;
        wait (loadDone);
        limitCycles = 20 + 16 * numWords + 4 * expAddr.size(); // reset plus program length
        #(limitCycles * ClockPeriod);
        $display("timeout: the program did not reach its final branch within %0d cycles",
                 limitCycles);
        $display("TEST FAILED");
        $finish;
    end

endmodule

// File: verification/cpu_vectors.txt
# I <program address> <instruction word>, M <data address> <initial value>,
# S <store address> <stored value> in completion order, all hex
I 0000 1205 mv r1, #5
I 0001 15FD mv r2, #-3
I 0002 3612 mvt r3, #0x12
I 0003 1820 mv r4, #0x20
I 0004 4202 add r1, r2
I 0005 7407 sub r2, #7
I 0006 A604 st r3, [r4]
I 0007 B221 st r1, [0x21]
I 0008 B422 st r2, [0x22]
I 0009 D4F0 and r2, #0x0F0
I 000A 73F0 sub r1, #-16
I 000B 1A7C mv r5, #0x7C
I 000C 9C30 ld r6, [0x30]
I 000D B423 st r2, [0x23]
I 000E CA02 and r5, r2
I 000F BC24 st r6, [0x24]
I 0010 B225 st r1, [0x25]
I 0011 8E05 ld r7, [r5]
I 0012 2002 b +2
I 0013 BC26 st r6, [0x26] flushed after the branch
I 0014 BC27 st r6, [0x27] skipped
I 0015 BE26 st r7, [0x26]
I 0016 BA27 st r5, [0x27]
I 0017 0207 mv r1, r7
I 0018 6805 sub r4, r5
I 0019 E000 nop
I 001A B228 st r1, [0x28]
I 001B B829 st r4, [0x29]
I 001C 21FF b -1 final self-branch
M 0030 BEEF
M 0070 5A3C
S 0020 1200
S 0021 0002
S 0022 FFF6
S 0023 00F0
S 0024 BEEF
S 0025 0012
S 0026 5A3C
S 0027 0070
S 0028 5A3C
S 0029 FFB0

// File: src.f
+incdir+include
rtl/cpuPkg.sv
rtl/regFile.sv
rtl/instrDecode.sv
rtl/aluExecute.sv
rtl/memResult.sv
rtl/cpuCore.sv
verification/cpuCore_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -Wno-fatal
TOP       ?= cpuCore_tb
FILELIST  ?= src.f
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^TEST OK$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
